/* bus_config.svh */
// bus configuration shared by rtl and testbench
// window masks select the address bits compared against the base
// the ram is far smaller than its 1 MB window, so word addresses wrap
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// hosts on the shared data bus
`define BUS_NUM_HOSTS 4
`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// ram window, 1 MB
`define RAM_BASE 32'h0010_0000
`define RAM_MASK 32'hFFF0_0000
// timer window, 1 kB
`define TIMER_BASE 32'h0003_0000
`define TIMER_MASK 32'hFFFF_FC00

// ram words actually implemented
`define SRAM_DEPTH 1024

// timer register byte offsets inside the window
`define TIMER_MTIME_LO 32'h0
`define TIMER_MTIME_HI 32'h4
`define TIMER_CMP_LO 32'h8
`define TIMER_CMP_HI 32'hC

`endif

/* bus_pkg.sv */
// bus types shared by rtl and testbench
// widths follow bus_config.svh, byte lanes are 8 bits
`include "bus_config.svh"

package bus_pkg;

  // host index needs at least one bit even for a single host
  localparam int unsigned host_idx_w = (`BUS_NUM_HOSTS > 1) ? $clog2(`BUS_NUM_HOSTS) : 1;

  typedef logic [`BUS_ADDR_W-1:0] addr_t;
  typedef logic [`BUS_DATA_W-1:0] data_t;
  typedef logic [`BUS_DATA_W/8-1:0] be_t;
  typedef logic [host_idx_w-1:0] host_idx_t;

  // target of a request, none means unmapped
  typedef enum logic [1:0] {
    dev_none  = 2'd0,
    dev_ram   = 2'd1,
    dev_timer = 2'd2
  } device_e;

  // replace the enabled byte lanes of a word
  function automatic data_t byte_merge(data_t old_word, data_t new_word, be_t be);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < `BUS_DATA_W / 8; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

/* host_arbiter.sv */
// fixed-priority arbiter, host 0 wins
// purely combinational, gnt comes in the same cycle as req
// a host that loses keeps req high until it is granted
`timescale 1ns/1ns
`include "bus_config.svh"

module host_arbiter (
  input  logic                host_req_i   [`BUS_NUM_HOSTS],
  input  bus_pkg::addr_t      host_addr_i  [`BUS_NUM_HOSTS],
  input  logic                host_we_i    [`BUS_NUM_HOSTS],
  input  bus_pkg::be_t        host_be_i    [`BUS_NUM_HOSTS],
  input  bus_pkg::data_t      host_wdata_i [`BUS_NUM_HOSTS],
  output logic                host_gnt_o   [`BUS_NUM_HOSTS],
  output logic                sel_valid_o,
  output bus_pkg::host_idx_t  sel_host_o,
  output bus_pkg::addr_t      sel_addr_o,
  output logic                sel_we_o,
  output bus_pkg::be_t        sel_be_o,
  output bus_pkg::data_t      sel_wdata_o
);

  // walk from the highest index down so the lowest requester ends up selected
  always_comb begin
    sel_valid_o = 1'b0;
    sel_host_o  = '0;
    sel_addr_o  = '0;
    sel_we_o    = 1'b0;
    sel_be_o    = '0;
    sel_wdata_o = '0;
    for (int h = `BUS_NUM_HOSTS - 1; h >= 0; h--) begin
      if (host_req_i[h]) begin
        sel_valid_o = 1'b1;
        sel_host_o  = bus_pkg::host_idx_t'(h);
        sel_addr_o  = host_addr_i[h];
        sel_we_o    = host_we_i[h];
        sel_be_o    = host_be_i[h];
        sel_wdata_o = host_wdata_i[h];
      end
    end
  end

  // one-hot grant back to the winner
  always_comb begin
    for (int h = 0; h < `BUS_NUM_HOSTS; h++) begin
      host_gnt_o[h] = sel_valid_o && (sel_host_o == bus_pkg::host_idx_t'(h));
    end
  end

endmodule

/* device_router.sv */
// address decode of the granted request
// windows from bus_config.svh must not overlap
// an unmapped address raises no device request, only dev_none
`timescale 1ns/1ns
`include "bus_config.svh"

module device_router (
  input  logic              sel_valid_i,
  input  bus_pkg::addr_t    sel_addr_i,
  input  logic              sel_we_i,
  input  bus_pkg::be_t      sel_be_i,
  input  bus_pkg::data_t    sel_wdata_i,
  output logic              ram_req_o,
  output logic              timer_req_o,
  output bus_pkg::addr_t    dev_addr_o,
  output logic              dev_we_o,
  output bus_pkg::be_t      dev_be_o,
  output bus_pkg::data_t    dev_wdata_o,
  output bus_pkg::device_e  sel_device_o
);

  logic ram_hit;
  logic timer_hit;

  // masked compare against each window base
  assign ram_hit   = (sel_addr_i & `RAM_MASK) == `RAM_BASE;
  assign timer_hit = (sel_addr_i & `TIMER_MASK) == `TIMER_BASE;

  // target selection, ram checked first
  always_comb begin
    sel_device_o = bus_pkg::dev_none;
    if (sel_valid_i) begin
      if (ram_hit) begin
        sel_device_o = bus_pkg::dev_ram;
      end else if (timer_hit) begin
        sel_device_o = bus_pkg::dev_timer;
      end
    end
  end

  // at most one device request per cycle
  assign ram_req_o   = (sel_device_o == bus_pkg::dev_ram);
  assign timer_req_o = (sel_device_o == bus_pkg::dev_timer);

  // shared request fields, each device qualifies them with its own req
  assign dev_addr_o  = sel_addr_i;
  assign dev_we_o    = sel_we_i;
  assign dev_be_o    = sel_be_i;
  assign dev_wdata_o = sel_wdata_i;

endmodule

/* response_return.sv */
// response path back to the granted host
// one register stage, responses cannot be stalled
// rdata is zero whenever err is set
`timescale 1ns/1ns
`include "bus_config.svh"

module response_return (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                sel_valid_i,
  input  bus_pkg::host_idx_t  sel_host_i,
  input  bus_pkg::device_e    sel_device_i,
  input  logic                ram_rvalid_i,
  input  bus_pkg::data_t      ram_rdata_i,
  input  logic                timer_rvalid_i,
  input  bus_pkg::data_t      timer_rdata_i,
  input  logic                timer_err_i,
  output logic                host_rvalid_o [`BUS_NUM_HOSTS],
  output bus_pkg::data_t      host_rdata_o  [`BUS_NUM_HOSTS],
  output logic                host_err_o    [`BUS_NUM_HOSTS]
);

  logic               pend_valid_q;
  bus_pkg::host_idx_t pend_host_q;
  bus_pkg::device_e   pend_dev_q;
  logic               resp_valid;
  logic               resp_err;
  bus_pkg::data_t     resp_rdata;

  // request in flight from last cycle's grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_valid_q <= 1'b0;
    end else begin
      pend_valid_q <= sel_valid_i;
    end
  end

  // who asked and where it went
  always_ff @(posedge clk_i) begin
    pend_host_q <= sel_host_i;
    pend_dev_q  <= sel_device_i;
  end

  // pick the answering device
  always_comb begin
    resp_valid = 1'b0;
    resp_err   = 1'b0;
    resp_rdata = '0;
    case (pend_dev_q)
      bus_pkg::dev_ram: begin
        resp_valid = pend_valid_q && ram_rvalid_i;
        resp_rdata = ram_rdata_i;
      end
      bus_pkg::dev_timer: begin
        resp_valid = pend_valid_q && timer_rvalid_i;
        resp_err   = timer_err_i;
        resp_rdata = timer_err_i ? '0 : timer_rdata_i;
      end
      default: begin
        // unmapped, answered by the bus itself
        resp_valid = pend_valid_q;
        resp_err   = 1'b1;
      end
    endcase
  end

  // steer to the pending host only, rdata is shared
  always_comb begin
    for (int h = 0; h < `BUS_NUM_HOSTS; h++) begin
      host_rvalid_o[h] = resp_valid && (pend_host_q == bus_pkg::host_idx_t'(h));
      host_err_o[h]    = host_rvalid_o[h] && resp_err;
      host_rdata_o[h]  = resp_rdata;
    end
  end

endmodule

/* sram_device.sv */
// single-port word ram behind the bus
// depth is SRAM_DEPTH words, upper address bits are ignored so accesses wrap
// rdata of a write returns the merged word
`timescale 1ns/1ns
`include "bus_config.svh"

module sram_device (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            req_i,
  input  logic            we_i,
  input  bus_pkg::be_t    be_i,
  input  bus_pkg::addr_t  addr_i,
  input  bus_pkg::data_t  wdata_i,
  output logic            rvalid_o,
  output bus_pkg::data_t  rdata_o
);

  localparam int unsigned idx_w = $clog2(`SRAM_DEPTH);

  bus_pkg::data_t   mem [`SRAM_DEPTH];
  logic [idx_w-1:0] word_idx;
  bus_pkg::data_t   merged;

  // word address, byte offset dropped
  assign word_idx = addr_i[2 +: idx_w];

  // word as it stands after this access
  assign merged = we_i ? bus_pkg::byte_merge(mem[word_idx], wdata_i, be_i) : mem[word_idx];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[word_idx] <= merged;
      end
      rdata_o <= merged;
    end
  end

  // every request answered next cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

/* timer_device.sv */
// 64-bit mtime / mtimecmp timer
// only the four word offsets are mapped, anything else answers err
// irq is registered, so it follows mtime >= mtimecmp by one cycle
`timescale 1ns/1ns
`include "bus_config.svh"

module timer_device (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            req_i,
  input  logic            we_i,
  input  bus_pkg::be_t    be_i,
  input  bus_pkg::addr_t  addr_i,
  input  bus_pkg::data_t  wdata_i,
  output logic            rvalid_o,
  output bus_pkg::data_t  rdata_o,
  output logic            err_o,
  output logic            timer_irq_o
);

  logic [63:0]    mtime_q;
  logic [63:0]    mtime_d;
  logic [63:0]    cmp_q;
  logic [63:0]    cmp_d;
  bus_pkg::addr_t reg_off;
  logic           bad_off;
  logic           wr;
  bus_pkg::data_t rd_word;

  // offset inside the 1 kB window
  assign reg_off = addr_i & ~`TIMER_MASK;
  assign wr      = req_i && we_i;

  // register read mux and offset check
  always_comb begin
    bad_off = 1'b0;
    rd_word = '0;
    case (reg_off)
      `TIMER_MTIME_LO: rd_word = mtime_q[31:0];
      `TIMER_MTIME_HI: rd_word = mtime_q[63:32];
      `TIMER_CMP_LO:   rd_word = cmp_q[31:0];
      `TIMER_CMP_HI:   rd_word = cmp_q[63:32];
      default:         bad_off = 1'b1;
    endcase
  end

  // mtime free-runs, a write overrides this cycle's increment
  always_comb begin
    mtime_d = mtime_q + 64'd1;
    cmp_d   = cmp_q;
    if (wr) begin
      case (reg_off)
        `TIMER_MTIME_LO: mtime_d[31:0] = bus_pkg::byte_merge(mtime_q[31:0], wdata_i, be_i);
        `TIMER_MTIME_HI: mtime_d[63:32] = bus_pkg::byte_merge(mtime_q[63:32], wdata_i, be_i);
        `TIMER_CMP_LO:   cmp_d[31:0] = bus_pkg::byte_merge(cmp_q[31:0], wdata_i, be_i);
        `TIMER_CMP_HI:   cmp_d[63:32] = bus_pkg::byte_merge(cmp_q[63:32], wdata_i, be_i);
        default:         ;
      endcase
    end
  end

  // cmp at all ones keeps irq quiet after reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mtime_q     <= '0;
      cmp_q       <= '1;
      rvalid_o    <= 1'b0;
      err_o       <= 1'b0;
      timer_irq_o <= 1'b0;
    end else begin
      mtime_q     <= mtime_d;
      cmp_q       <= cmp_d;
      rvalid_o    <= req_i;
      err_o       <= req_i && bad_off;
      timer_irq_o <= (mtime_q >= cmp_q);
    end
  end

  // read data, pre-write value of the register
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rd_word;
    end
  end

endmodule

/* bus_system.sv */
// shared data bus: arbiter, router, ram, timer, response return
// hosts follow req/gnt/rvalid, rvalid exactly one cycle after gnt
// a new grant may overlap the previous response
`timescale 1ns/1ns
`include "bus_config.svh"

module bus_system (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            host_req_i    [`BUS_NUM_HOSTS],
  input  bus_pkg::addr_t  host_addr_i   [`BUS_NUM_HOSTS],
  input  logic            host_we_i     [`BUS_NUM_HOSTS],
  input  bus_pkg::be_t    host_be_i     [`BUS_NUM_HOSTS],
  input  bus_pkg::data_t  host_wdata_i  [`BUS_NUM_HOSTS],
  output logic            host_gnt_o    [`BUS_NUM_HOSTS],
  output logic            host_rvalid_o [`BUS_NUM_HOSTS],
  output bus_pkg::data_t  host_rdata_o  [`BUS_NUM_HOSTS],
  output logic            host_err_o    [`BUS_NUM_HOSTS],
  output logic            timer_irq_o
);

  // granted request
  logic               sel_valid;
  bus_pkg::host_idx_t sel_host;
  bus_pkg::addr_t     sel_addr;
  logic               sel_we;
  bus_pkg::be_t       sel_be;
  bus_pkg::data_t     sel_wdata;

  // decoded request to the devices
  logic               ram_req;
  logic               timer_req;
  bus_pkg::addr_t     dev_addr;
  logic               dev_we;
  bus_pkg::be_t       dev_be;
  bus_pkg::data_t     dev_wdata;
  bus_pkg::device_e   sel_device;

  // device responses
  logic               ram_rvalid;
  bus_pkg::data_t     ram_rdata;
  logic               timer_rvalid;
  bus_pkg::data_t     timer_rdata;
  logic               timer_err;

  host_arbiter u_host_arbiter (
    .host_req_i   (host_req_i),
    .host_addr_i  (host_addr_i),
    .host_we_i    (host_we_i),
    .host_be_i    (host_be_i),
    .host_wdata_i (host_wdata_i),
    .host_gnt_o   (host_gnt_o),
    .sel_valid_o  (sel_valid),
    .sel_host_o   (sel_host),
    .sel_addr_o   (sel_addr),
    .sel_we_o     (sel_we),
    .sel_be_o     (sel_be),
    .sel_wdata_o  (sel_wdata)
  );

  device_router u_device_router (
    .sel_valid_i  (sel_valid),
    .sel_addr_i   (sel_addr),
    .sel_we_i     (sel_we),
    .sel_be_i     (sel_be),
    .sel_wdata_i  (sel_wdata),
    .ram_req_o    (ram_req),
    .timer_req_o  (timer_req),
    .dev_addr_o   (dev_addr),
    .dev_we_o     (dev_we),
    .dev_be_o     (dev_be),
    .dev_wdata_o  (dev_wdata),
    .sel_device_o (sel_device)
  );

  sram_device u_sram_device (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (ram_req),
    .we_i     (dev_we),
    .be_i     (dev_be),
    .addr_i   (dev_addr),
    .wdata_i  (dev_wdata),
    .rvalid_o (ram_rvalid),
    .rdata_o  (ram_rdata)
  );

  timer_device u_timer_device (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (timer_req),
    .we_i        (dev_we),
    .be_i        (dev_be),
    .addr_i      (dev_addr),
    .wdata_i     (dev_wdata),
    .rvalid_o    (timer_rvalid),
    .rdata_o     (timer_rdata),
    .err_o       (timer_err),
    .timer_irq_o (timer_irq_o)
  );

  response_return u_response_return (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .sel_valid_i    (sel_valid),
    .sel_host_i     (sel_host),
    .sel_device_i   (sel_device),
    .ram_rvalid_i   (ram_rvalid),
    .ram_rdata_i    (ram_rdata),
    .timer_rvalid_i (timer_rvalid),
    .timer_rdata_i  (timer_rdata),
    .timer_err_i    (timer_err),
    .host_rvalid_o  (host_rvalid_o),
    .host_rdata_o   (host_rdata_o),
    .host_err_o     (host_err_o)
  );

endmodule

/* bus_system_properties.sv */
// protocol assertions for the bus, bound into the top level
// reset checks look one edge after reset is seen, registers are unknown before
`timescale 1ns/1ns
`include "bus_config.svh"

module bus_system_properties (
  input logic clk_i,
  input logic rst_n_i,
  input logic host_gnt_o    [`BUS_NUM_HOSTS],
  input logic host_rvalid_o [`BUS_NUM_HOSTS],
  input logic timer_irq_o
);

  logic [`BUS_NUM_HOSTS-1:0] rvalid_vec;

  // packed view for the one-hot check
  always_comb begin
    for (int h = 0; h < `BUS_NUM_HOSTS; h++) begin
      rvalid_vec[h] = host_rvalid_o[h];
    end
  end

  for (genvar h = 0; h < `BUS_NUM_HOSTS; h++) begin : g_host
    // response only after a grant to the same host
    rvalid_after_gnt_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      host_rvalid_o[h] |-> $past(host_gnt_o[h]))
      else $error("host %0d got rvalid without a grant one cycle earlier", h);
  end

  one_rvalid_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(rvalid_vec))
    else $error("more than one host sees rvalid in the same cycle");

  quiet_in_reset_a : assert property (@(posedge clk_i)
    !rst_n_i |=> (rvalid_vec == '0) && !timer_irq_o)
    else $error("rvalid or timer irq active while in reset");

endmodule

bind bus_system bus_system_properties u_bus_system_properties (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .host_gnt_o    (host_gnt_o),
  .host_rvalid_o (host_rvalid_o),
  .timer_irq_o   (timer_irq_o)
);

/* tb_bus_system.sv */
// directed tests for the shared data bus
// inputs change on the rising edge, outputs are sampled on the falling edge
// needs BUS_NUM_HOSTS of at least 2, ram tests assume the ram is written first
`timescale 1ns/1ns
`include "bus_config.svh"

module tb_bus_system;

  localparam int num_hosts      = `BUS_NUM_HOSTS;
  localparam int words_per_host = 8;
  // rough length of all tests in cycles, the watchdog allows twice this
  localparam int test_cycles    = 1500;

  logic               clk;
  logic               rst_n;
  logic               host_req    [`BUS_NUM_HOSTS];
  bus_pkg::addr_t     host_addr   [`BUS_NUM_HOSTS];
  logic               host_we     [`BUS_NUM_HOSTS];
  bus_pkg::be_t       host_be     [`BUS_NUM_HOSTS];
  bus_pkg::data_t     host_wdata  [`BUS_NUM_HOSTS];
  logic               host_gnt    [`BUS_NUM_HOSTS];
  logic               host_rvalid [`BUS_NUM_HOSTS];
  bus_pkg::data_t     host_rdata  [`BUS_NUM_HOSTS];
  logic               host_err    [`BUS_NUM_HOSTS];
  logic               timer_irq;

  integer             seed;
  int                 error_count;
  // ram model, one word per implemented ram entry
  bus_pkg::data_t     model_mem   [`SRAM_DEPTH];
  // hosts in the order they saw gnt
  bus_pkg::host_idx_t grant_order [$];
  bus_pkg::data_t     prio_rdata  [`BUS_NUM_HOSTS];
  logic               prio_err    [`BUS_NUM_HOSTS];

  bus_system dut_i (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .host_req_i    (host_req),
    .host_addr_i   (host_addr),
    .host_we_i     (host_we),
    .host_be_i     (host_be),
    .host_wdata_i  (host_wdata),
    .host_gnt_o    (host_gnt),
    .host_rvalid_o (host_rvalid),
    .host_rdata_o  (host_rdata),
    .host_err_o    (host_err),
    .timer_irq_o   (timer_irq)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // per bit: enabled lanes take the new data
  function automatic bus_pkg::data_t apply_be(bus_pkg::data_t old_word,
                                              bus_pkg::data_t new_word, bus_pkg::be_t be);
    bus_pkg::data_t result;
    for (int i = 0; i < `BUS_DATA_W; i++) begin
      result[i] = be[i / 8] ? new_word[i] : old_word[i];
    end
    return result;
  endfunction

  // ram entry hit by a byte address, wraps every SRAM_DEPTH words
  function automatic int ram_index(bus_pkg::addr_t addr);
    return (addr >> 2) % `SRAM_DEPTH;
  endfunction

  function automatic bus_pkg::addr_t ram_addr(int word);
    return `RAM_BASE + word * 4;
  endfunction

  task automatic check_data(string test_name, bus_pkg::data_t exp, bus_pkg::data_t act);
    if (act !== exp) begin
      error_count++;
      $display("FAILED %s: expected %h, actual %h", test_name, exp, act);
    end
  endtask

  // single-bit results (err, rvalid, irq)
  task automatic check_err(string test_name, logic exp, logic act);
    if (act !== exp) begin
      error_count++;
      $display("FAILED %s: expected %b, actual %b", test_name, exp, act);
    end
  endtask

  task automatic check_host(string test_name, bus_pkg::host_idx_t exp,
                            bus_pkg::host_idx_t act);
    if (act !== exp) begin
      error_count++;
      $display("FAILED %s: expected %0d, actual %0d", test_name, exp, act);
    end
  endtask

  // one request on host h, held until gnt, response checked one cycle later
  task automatic bus_access(input int h, input bus_pkg::addr_t addr, input logic we,
                            input bus_pkg::be_t be, input bus_pkg::data_t wdata,
                            output bus_pkg::data_t rdata, output logic err);
    @(posedge clk);
    host_req[h]   <= 1'b1;
    host_addr[h]  <= addr;
    host_we[h]    <= we;
    host_be[h]    <= be;
    host_wdata[h] <= wdata;
    @(negedge clk);
    while (!host_gnt[h]) begin
      @(negedge clk);
    end
    grant_order.push_back(bus_pkg::host_idx_t'(h));
    @(posedge clk);
    host_req[h] <= 1'b0;
    // response cycle, granted host only
    @(negedge clk);
    check_err("rvalid_after_gnt", 1'b1, host_rvalid[h]);
    for (int o = 0; o < num_hosts; o++) begin
      if (o != h && host_rvalid[o] !== 1'b0) begin
        error_count++;
        $display("rvalid seen on host %0d during the response to host %0d", o, h);
      end
    end
    rdata = host_rdata[h];
    err   = host_err[h];
  endtask

  task automatic test_reset();
    @(negedge clk);
    for (int h = 0; h < num_hosts; h++) begin
      check_err("reset_gnt", 1'b0, host_gnt[h]);
      check_err("reset_rvalid", 1'b0, host_rvalid[h]);
    end
    check_err("reset_irq", 1'b0, timer_irq);
  endtask

  // full words, then partial writes through aliases, then reads
  task automatic test_ram();
    bus_pkg::addr_t addr;
    bus_pkg::data_t wdata;
    bus_pkg::data_t rdata;
    bus_pkg::be_t   be;
    logic           err;
    int             word;
    for (int h = 0; h < num_hosts; h++) begin
      for (int w = 0; w < words_per_host; w++) begin
        word  = h * words_per_host + w;
        addr  = ram_addr(word);
        wdata = $random(seed);
        bus_access(h, addr, 1'b1, '1, wdata, rdata, err);
        model_mem[ram_index(addr)] = wdata;
        check_err("ram_write_full", 1'b0, err);
      end
    end
    for (int h = 0; h < num_hosts; h++) begin
      for (int w = 0; w < words_per_host; w++) begin
        // one to eight ram sizes above the word, same entry
        word  = h * words_per_host + w;
        addr  = ram_addr(word + (w + 1) * `SRAM_DEPTH);
        wdata = $random(seed);
        be    = bus_pkg::be_t'($random(seed));
        bus_access(h, addr, 1'b1, be, wdata, rdata, err);
        model_mem[ram_index(addr)] = apply_be(model_mem[ram_index(addr)], wdata, be);
        check_err("ram_write_alias", 1'b0, err);
      end
    end
    for (int h = 0; h < num_hosts; h++) begin
      for (int w = 0; w < words_per_host; w++) begin
        addr = ram_addr(h * words_per_host + w);
        bus_access(h, addr, 1'b0, '0, '0, rdata, err);
        check_err("ram_read_err", 1'b0, err);
        check_data("ram_read", model_mem[ram_index(addr)], rdata);
      end
    end
  endtask

  // hosts in mask request on the same edge, lowest index must win first
  task automatic contend(string test_name, logic [`BUS_NUM_HOSTS-1:0] mask);
    bus_pkg::host_idx_t exp_order [$];
    grant_order.delete();
    for (int h = 0; h < num_hosts; h++) begin
      if (mask[h]) begin
        exp_order.push_back(bus_pkg::host_idx_t'(h));
        fork
          automatic int hh = h;
          bus_access(hh, ram_addr(hh * words_per_host + 1), 1'b0, '0, '0,
                     prio_rdata[hh], prio_err[hh]);
        join_none
      end
    end
    wait fork;
    if (grant_order.size() != exp_order.size()) begin
      error_count++;
      $display("%s: %0d grants seen for %0d requesting hosts", test_name,
               grant_order.size(), exp_order.size());
    end else begin
      for (int i = 0; i < exp_order.size(); i++) begin
        check_host(test_name, exp_order[i], grant_order[i]);
      end
    end
    for (int h = 0; h < num_hosts; h++) begin
      if (mask[h]) begin
        check_err(test_name, 1'b0, prio_err[h]);
        check_data(test_name, model_mem[h * words_per_host + 1], prio_rdata[h]);
      end
    end
  endtask

  task automatic test_priority();
    logic [`BUS_NUM_HOSTS-1:0] pair;
    pair                = '0;
    pair[1]             = 1'b1;
    pair[num_hosts - 1] = 1'b1;
    contend("priority_all", '1);
    contend("priority_pair", pair);
  endtask

  task automatic test_unmapped();
    bus_pkg::addr_t addr;
    bus_pkg::data_t rdata;
    logic           err;
    // low bits alias ram word 3, but outside both windows
    addr = 32'h0020_0000 + 3 * 4;
    bus_access(num_hosts - 1, addr, 1'b1, '1, $random(seed), rdata, err);
    check_err("unmapped_write_err", 1'b1, err);
    check_data("unmapped_write_rdata", '0, rdata);
    bus_access(num_hosts - 1, addr, 1'b0, '0, '0, rdata, err);
    check_err("unmapped_read_err", 1'b1, err);
    check_data("unmapped_read_rdata", '0, rdata);
    bus_access(0, ram_addr(3), 1'b0, '0, '0, rdata, err);
    check_data("unmapped_ram_kept", model_mem[3], rdata);
  endtask

  task automatic test_timer();
    bus_pkg::data_t lo_word;
    bus_pkg::data_t hi_word;
    bus_pkg::data_t rdata;
    logic           err;
    logic [63:0]    target;
    int             wait_cnt;
    check_err("timer_irq_idle", 1'b0, timer_irq);
    // compare register readback
    lo_word = $random(seed);
    hi_word = $random(seed) | 32'h8000_0000;
    bus_access(0, `TIMER_BASE + `TIMER_CMP_LO, 1'b1, '1, lo_word, rdata, err);
    bus_access(0, `TIMER_BASE + `TIMER_CMP_HI, 1'b1, '1, hi_word, rdata, err);
    bus_access(0, `TIMER_BASE + `TIMER_CMP_LO, 1'b0, '0, '0, rdata, err);
    check_data("timer_cmp_lo", lo_word, rdata);
    bus_access(0, `TIMER_BASE + `TIMER_CMP_HI, 1'b0, '0, '0, rdata, err);
    check_data("timer_cmp_hi", hi_word, rdata);
    // first offset past the four registers
    bus_access(0, `TIMER_BASE + 32'h10, 1'b0, '0, '0, rdata, err);
    check_err("timer_bad_offset_err", 1'b1, err);
    check_data("timer_bad_offset_rdata", '0, rdata);
    // compare a little ahead of now, hi parked high while lo changes
    bus_access(0, `TIMER_BASE + `TIMER_MTIME_LO, 1'b0, '0, '0, lo_word, err);
    bus_access(0, `TIMER_BASE + `TIMER_MTIME_HI, 1'b0, '0, '0, hi_word, err);
    target = {hi_word, lo_word} + 64'd40;
    bus_access(0, `TIMER_BASE + `TIMER_CMP_HI, 1'b1, '1, '1, rdata, err);
    bus_access(0, `TIMER_BASE + `TIMER_CMP_LO, 1'b1, '1, target[31:0], rdata, err);
    bus_access(0, `TIMER_BASE + `TIMER_CMP_HI, 1'b1, '1, target[63:32], rdata, err);
    check_err("timer_irq_before", 1'b0, timer_irq);
    wait_cnt = 0;
    while (timer_irq !== 1'b1 && wait_cnt < 100) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (timer_irq !== 1'b1) begin
      error_count++;
      $display("timer interrupt did not rise within 100 cycles of the compare write");
    end
    // all ones parks the compare out of reach
    bus_access(0, `TIMER_BASE + `TIMER_CMP_HI, 1'b1, '1, '1, rdata, err);
    bus_access(0, `TIMER_BASE + `TIMER_CMP_LO, 1'b1, '1, '1, rdata, err);
    @(negedge clk);
    check_err("timer_irq_cleared", 1'b0, timer_irq);
  endtask

  initial begin
    seed        = 32'he282;
    error_count = 0;
    rst_n       = 1'b0;
    for (int h = 0; h < num_hosts; h++) begin
      host_req[h]   = 1'b0;
      host_addr[h]  = '0;
      host_we[h]    = 1'b0;
      host_be[h]    = '0;
      host_wdata[h] = '0;
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_ram();
    test_priority();
    test_unmapped();
    test_timer();
    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (2 * test_cycles) @(posedge clk);
    $display("timeout: tests still running after %0d cycles", 2 * test_cycles);
    $display("test failed");
    $finish;
  end

endmodule

/* build.f */
+incdir+.
bus_pkg.sv
host_arbiter.sv
device_router.sv
response_return.sv
sram_device.sv
timer_device.sv
bus_system.sv
bus_system_properties.sv
tb_bus_system.sv

/* run.sh */
#!/bin/sh
# build and run the bus testbench with Verilator, output collected in sim.log
# a simulator error status is turned into a failing log
verilator --binary --timing --assert --top-module tb_bus_system -f build.f \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_bus_system > sim.log 2>&1 \
  || echo "test failed" >> sim.log
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0
